// File: bench/cpu_core_tb.sv
module cpu_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int golden_depth = 128;
  localparam int exp_base     = 64;
  localparam int wb_timeout   = 20;

  logic               clk;
  logic               arst_n;
  logic               instr_valid;
  cpu_pkg::data_t     instr;
  logic               wb_valid;
  cpu_pkg::reg_addr_t wb_reg;
  cpu_pkg::data_t     wb_data;

  // program entries below exp_base and expected writebacks from exp_base up
  logic [39:0] golden [golden_depth];
  int          n_prog;
  int          n_exp;
  logic [31:0] lfsr_state;

  cpu_core #(
    .dmem_words (64)
  ) dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Error: at %0t, %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic load_golden();
    for (int i = 0; i < golden_depth; i++) begin
      golden[i] = '1;
    end
    $readmemh("bench/cpu_golden.txt", golden);
    n_prog = 0;
    while (n_prog < exp_base && golden[n_prog][39:32] != 8'hff) begin
      n_prog++;
    end
    n_exp = 0;
    while (n_exp < golden_depth - exp_base && golden[exp_base + n_exp][39:32] != 8'hff) begin
      n_exp++;
    end
    if (n_prog == 0 || n_exp == 0) begin
      stop_with_failure("golden file holds no program or no expected writebacks");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and monitor
  ////////////////////////////////////////////////////////////

  task automatic drive_program();
    int gap;
    for (int k = 0; k < n_prog; k++) begin
      pick_gap(gap);
      // a load result is not ready for the next slot
      if (golden[k][32] && gap == 0) begin
        gap = 1;
      end
      repeat (gap) begin
        @(negedge clk);
        instr_valid <= 1'b0;
        instr       <= '0;
      end
      @(negedge clk);
      instr_valid <= 1'b1;
      instr       <= golden[k][31:0];
    end
    @(negedge clk);
    instr_valid <= 1'b0;
    instr       <= '0;
  endtask

  task automatic collect_writebacks();
    int waited;
    for (int k = 0; k < n_exp; k++) begin
      waited = 0;
      @(negedge clk);
      while (wb_valid !== 1'b1 && waited < wb_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (wb_valid !== 1'b1) begin
        stop_with_failure($sformatf("no writeback within %0d cycles, record %0d missing",
                                    wb_timeout, k));
      end else begin
        check_value("wb_reg", 32'(wb_reg), 32'(golden[exp_base + k][36:32]));
        check_value("wb_data", wb_data, golden[exp_base + k][31:0]);
      end
    end
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = 32'h53ca;
    load_golden();

    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;

    // quiet pipeline before the first instruction
    repeat (5) begin
      @(negedge clk);
      check_value("wb_valid", 32'(wb_valid), 32'd0);
    end

    fork
      drive_program();
      collect_writebacks();
    join

    // nothing may retire beyond the expected list
    repeat (6) begin
      @(negedge clk);
      check_value("wb_valid", 32'(wb_valid), 32'd0);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: bench/cpu_golden.txt
// program: flag nibble (1 = needs an idle slot before it) then the instruction word
// expected from @40: register index byte then the 32-bit written value
020010005 // addi r1, r0, 0x5
02002000c // addi r2, r0, 0xc
004221800 // add  r3, r1, r2
008222000 // sub  r4, r1, r2
014812800 // slt  r5, r4, r1
014243000 // slt  r6, r1, r4
010623800 // or   r7, r3, r2
00c644000 // and  r8, r3, r4
02009ffff // addi r9, r0, 0xffff
0ac090010 // sw   r9, 0x10(r0)
0200a1234 // addi r10, r0, 0x1234
0ac0a0020 // sw   r10, 0x20(r0)
08c0b0010 // lw   r11, 0x10(r0)
08c0c0020 // lw   r12, 0x20(r0)
1058b6800 // add  r13, r12, r11
020200007 // addi r0, r1, 0x7
004220000 // add  r0, r1, r2
004017000 // add  r14, r0, r1
010007800 // or   r15, r0, r0
008018000 // sub  r16, r0, r1
016008800 // slt  r17, r16, r0
08c32001b // lw   r18, 0x1b(r1)
10a419800 // sub  r19, r18, r1
0ae130000 // sw   r19, 0(r16)
08e140000 // lw   r20, 0(r16)
10e94a800 // and  r21, r20, r20
@40
0100000005
020000000c
0300000011
04fffffff9
0500000001
0600000000
070000001d
0800000011
090000ffff
0a00001234
0b0000ffff
0c00001234
0d00011233
0e00000005
0f00000000
10fffffffb
1100000001
1200001234
130000122f
140000122f
150000122f

// File: filelist.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_core.sv
bench/cpu_core_tb.sv

// File: rtl/alu.sv
module alu (
  input  cpu_pkg::alu_op_t alu_op,
  input  cpu_pkg::data_t   a,
  input  cpu_pkg::data_t   b,
  output cpu_pkg::data_t   result
);

  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      cpu_pkg::alu_add: begin
        result = a + b;
      end
      // wraps, no overflow flag
      cpu_pkg::alu_sub: begin
        result = a - b;
      end
      cpu_pkg::alu_and: begin
        result = a & b;
      end
      cpu_pkg::alu_or: begin
        result = a | b;
      end
      cpu_pkg::alu_slt: begin
        result = {{(cpu_pkg::data_width-1){1'b0}}, less};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: rtl/cpu_core.sv
module cpu_core #(
  parameter int dmem_words = 64
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  cpu_pkg::data_t     instr,
  output logic               wb_valid,
  output cpu_pkg::reg_addr_t wb_reg,
  output cpu_pkg::data_t     wb_data
);

  cpu_pkg::reg_addr_t rs_addr;
  cpu_pkg::reg_addr_t rt_addr;
  cpu_pkg::data_t     rs_data;
  cpu_pkg::data_t     rt_data;

  logic               ex_valid;
  cpu_pkg::alu_op_t   ex_alu_op;
  logic               ex_use_imm;
  logic               ex_load;
  logic               ex_store;
  logic               ex_wen;
  cpu_pkg::reg_addr_t ex_rs;
  cpu_pkg::reg_addr_t ex_rt;
  cpu_pkg::reg_addr_t ex_dst;
  cpu_pkg::data_t     ex_rs_data;
  cpu_pkg::data_t     ex_rt_data;
  cpu_pkg::data_t     ex_imm;

  logic               mem_valid;
  logic               mem_load;
  logic               mem_store;
  logic               mem_wen;
  cpu_pkg::reg_addr_t mem_dst;
  cpu_pkg::data_t     mem_result;
  cpu_pkg::data_t     mem_store_data;

  ////////////////////////////////////////////////////////////
  // decode and register file
  ////////////////////////////////////////////////////////////

  decode_stage decode0 (
    .clk (clk), .arst_n (arst_n), .instr_valid (instr_valid), .instr (instr),
    .rs_addr (rs_addr), .rt_addr (rt_addr), .rs_data (rs_data), .rt_data (rt_data),
    .ex_valid (ex_valid), .ex_alu_op (ex_alu_op), .ex_use_imm (ex_use_imm),
    .ex_load (ex_load), .ex_store (ex_store), .ex_wen (ex_wen),
    .ex_rs (ex_rs), .ex_rt (ex_rt), .ex_dst (ex_dst),
    .ex_rs_data (ex_rs_data), .ex_rt_data (ex_rt_data), .ex_imm (ex_imm)
  );

  // written from the writeback slot
  register_file regfile0 (
    .clk (clk), .arst_n (arst_n),
    .rd_addr_a (rs_addr), .rd_addr_b (rt_addr),
    .rd_data_a (rs_data), .rd_data_b (rt_data),
    .wr_en (wb_valid), .wr_addr (wb_reg), .wr_data (wb_data)
  );

  ////////////////////////////////////////////////////////////
  // execute, memory, writeback
  ////////////////////////////////////////////////////////////

  execute_stage execute0 (
    .clk (clk), .arst_n (arst_n),
    .ex_valid (ex_valid), .ex_alu_op (ex_alu_op), .ex_use_imm (ex_use_imm),
    .ex_load (ex_load), .ex_store (ex_store), .ex_wen (ex_wen),
    .ex_rs (ex_rs), .ex_rt (ex_rt), .ex_dst (ex_dst),
    .ex_rs_data (ex_rs_data), .ex_rt_data (ex_rt_data), .ex_imm (ex_imm),
    .wb_wen (wb_valid), .wb_dst (wb_reg), .wb_data (wb_data),
    .mem_valid (mem_valid), .mem_load (mem_load), .mem_store (mem_store),
    .mem_wen (mem_wen), .mem_dst (mem_dst), .mem_result (mem_result),
    .mem_store_data (mem_store_data)
  );

  memory_stage #(
    .dmem_words (dmem_words)
  ) memory0 (
    .clk (clk), .arst_n (arst_n),
    .mem_valid (mem_valid), .mem_load (mem_load), .mem_store (mem_store),
    .mem_wen (mem_wen), .mem_dst (mem_dst), .mem_result (mem_result),
    .mem_store_data (mem_store_data),
    .wb_valid (), .wb_wen (wb_valid), .wb_dst (wb_reg), .wb_data (wb_data)
  );

endmodule

// File: rtl/cpu_pkg.sv
package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // widths and basic types
  ////////////////////////////////////////////////////////////

  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;

  typedef logic [data_width-1:0]     data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////
  // instruction fields
  ////////////////////////////////////////////////////////////

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;

  // r-type ops write rd, the rest write rt
  typedef enum logic [opcode_msb-opcode_lsb:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_slt  = 6'h05,
    op_addi = 6'h08,
    op_lw   = 6'h23,
    op_sw   = 6'h2b
  } opcode_t;

  ////////////////////////////////////////////////////////////
  // execute controls
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  // operand source
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_t;

endpackage

// File: rtl/decode_stage.sv
module decode_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               instr_valid,
  input  cpu_pkg::data_t     instr,
  output cpu_pkg::reg_addr_t rs_addr,
  output cpu_pkg::reg_addr_t rt_addr,
  input  cpu_pkg::data_t     rs_data,
  input  cpu_pkg::data_t     rt_data,
  output logic               ex_valid,
  output cpu_pkg::alu_op_t   ex_alu_op,
  output logic               ex_use_imm,
  output logic               ex_load,
  output logic               ex_store,
  output logic               ex_wen,
  output cpu_pkg::reg_addr_t ex_rs,
  output cpu_pkg::reg_addr_t ex_rt,
  output cpu_pkg::reg_addr_t ex_dst,
  output cpu_pkg::data_t     ex_rs_data,
  output cpu_pkg::data_t     ex_rt_data,
  output cpu_pkg::data_t     ex_imm
);

  cpu_pkg::opcode_t   opcode;
  cpu_pkg::reg_addr_t rd_addr;
  cpu_pkg::data_t     imm_ext;
  cpu_pkg::alu_op_t   alu_op;
  cpu_pkg::reg_addr_t dst;
  logic               use_imm;
  logic               load;
  logic               store;
  logic               writes;
  logic               dst_is_rd;

  assign opcode  = cpu_pkg::opcode_t'(instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb]);
  assign rs_addr = instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
  assign rt_addr = instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
  assign rd_addr = instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
  assign imm_ext = {{(cpu_pkg::data_width-cpu_pkg::imm_width){1'b0}},
                    instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb]};

  ////////////////////////////////////////////////////////////
  // control unit
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = cpu_pkg::alu_add;
    use_imm   = 1'b0;
    load      = 1'b0;
    store     = 1'b0;
    writes    = 1'b0;
    dst_is_rd = 1'b0;
    case (opcode)
      cpu_pkg::op_add: begin
        writes    = 1'b1;
        dst_is_rd = 1'b1;
      end
      cpu_pkg::op_sub: begin
        alu_op    = cpu_pkg::alu_sub;
        writes    = 1'b1;
        dst_is_rd = 1'b1;
      end
      cpu_pkg::op_and: begin
        alu_op    = cpu_pkg::alu_and;
        writes    = 1'b1;
        dst_is_rd = 1'b1;
      end
      cpu_pkg::op_or: begin
        alu_op    = cpu_pkg::alu_or;
        writes    = 1'b1;
        dst_is_rd = 1'b1;
      end
      cpu_pkg::op_slt: begin
        alu_op    = cpu_pkg::alu_slt;
        writes    = 1'b1;
        dst_is_rd = 1'b1;
      end
      cpu_pkg::op_addi: begin
        use_imm = 1'b1;
        writes  = 1'b1;
      end
      cpu_pkg::op_lw: begin
        use_imm = 1'b1;
        load    = 1'b1;
        writes  = 1'b1;
      end
      cpu_pkg::op_sw: begin
        use_imm = 1'b1;
        store   = 1'b1;
      end
      // nop and unknown opcodes
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  assign dst = dst_is_rd ? rd_addr : rt_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid   <= 1'b0;
      ex_alu_op  <= cpu_pkg::alu_add;
      ex_use_imm <= 1'b0;
      ex_load    <= 1'b0;
      ex_store   <= 1'b0;
      ex_wen     <= 1'b0;
    end else begin
      ex_valid   <= instr_valid;
      ex_alu_op  <= alu_op;
      ex_use_imm <= use_imm;
      ex_load    <= load;
      ex_store   <= store;
      // r0 is never written
      ex_wen     <= writes && dst != '0;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs      <= rs_addr;
    ex_rt      <= rt_addr;
    ex_dst     <= dst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_imm     <= imm_ext;
  end

endmodule

// File: rtl/execute_stage.sv
module execute_stage (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               ex_valid,
  input  cpu_pkg::alu_op_t   ex_alu_op,
  input  logic               ex_use_imm,
  input  logic               ex_load,
  input  logic               ex_store,
  input  logic               ex_wen,
  input  cpu_pkg::reg_addr_t ex_rs,
  input  cpu_pkg::reg_addr_t ex_rt,
  input  cpu_pkg::reg_addr_t ex_dst,
  input  cpu_pkg::data_t     ex_rs_data,
  input  cpu_pkg::data_t     ex_rt_data,
  input  cpu_pkg::data_t     ex_imm,
  input  logic               wb_wen,
  input  cpu_pkg::reg_addr_t wb_dst,
  input  cpu_pkg::data_t     wb_data,
  output logic               mem_valid,
  output logic               mem_load,
  output logic               mem_store,
  output logic               mem_wen,
  output cpu_pkg::reg_addr_t mem_dst,
  output cpu_pkg::data_t     mem_result,
  output cpu_pkg::data_t     mem_store_data
);

  cpu_pkg::fwd_sel_t fwd_a;
  cpu_pkg::fwd_sel_t fwd_b;
  cpu_pkg::data_t    op_a;
  cpu_pkg::data_t    op_b;
  cpu_pkg::data_t    alu_b;
  cpu_pkg::data_t    alu_result;

  function automatic cpu_pkg::data_t pick_operand(
    input cpu_pkg::fwd_sel_t sel,
    input cpu_pkg::data_t    reg_val,
    input cpu_pkg::data_t    ex_mem_val,
    input cpu_pkg::data_t    mem_wb_val
  );
    case (sel)
      cpu_pkg::fwd_ex_mem: return ex_mem_val;
      cpu_pkg::fwd_mem_wb: return mem_wb_val;
      default:             return reg_val;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // forwarding, newer result first
  ////////////////////////////////////////////////////////////

  assign fwd_a = (mem_valid && mem_wen && mem_dst == ex_rs) ? cpu_pkg::fwd_ex_mem :
                 (wb_wen && wb_dst == ex_rs)                ? cpu_pkg::fwd_mem_wb :
                                                              cpu_pkg::fwd_none;
  assign fwd_b = (mem_valid && mem_wen && mem_dst == ex_rt) ? cpu_pkg::fwd_ex_mem :
                 (wb_wen && wb_dst == ex_rt)                ? cpu_pkg::fwd_mem_wb :
                                                              cpu_pkg::fwd_none;

  assign op_a  = pick_operand(fwd_a, ex_rs_data, mem_result, wb_data);
  assign op_b  = pick_operand(fwd_b, ex_rt_data, mem_result, wb_data);
  assign alu_b = ex_use_imm ? ex_imm : op_b;

  alu alu0 (
    .alu_op (ex_alu_op),
    .a      (op_a),
    .b      (alu_b),
    .result (alu_result)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_valid <= 1'b0;
      mem_load  <= 1'b0;
      mem_store <= 1'b0;
      mem_wen   <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      mem_load  <= ex_load;
      mem_store <= ex_store;
      mem_wen   <= ex_wen;
    end
  end

  always_ff @(posedge clk) begin
    mem_dst        <= ex_dst;
    mem_result     <= alu_result;
    mem_store_data <= op_b;
  end

  // no interlock, a load result is not ready for the next slot
  load_use_gap: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mem_valid && mem_load && mem_wen && ex_valid) |->
      !(((ex_wen || ex_store) && ex_rs == mem_dst) ||
        (((ex_wen && !ex_use_imm) || ex_store) && ex_rt == mem_dst))
  );

endmodule

// File: rtl/memory_stage.sv
module memory_stage #(
  parameter int dmem_words = 64
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               mem_valid,
  input  logic               mem_load,
  input  logic               mem_store,
  input  logic               mem_wen,
  input  cpu_pkg::reg_addr_t mem_dst,
  input  cpu_pkg::data_t     mem_result,
  input  cpu_pkg::data_t     mem_store_data,
  output logic               wb_valid,
  output logic               wb_wen,
  output cpu_pkg::reg_addr_t wb_dst,
  output cpu_pkg::data_t     wb_data
);

  localparam int addr_width = $clog2(dmem_words);

  cpu_pkg::data_t          dmem [dmem_words];
  logic [addr_width-1:0]   word_idx;
  cpu_pkg::data_t          load_data;
  logic                    wb_wen_q;
  logic                    wb_load_q;
  cpu_pkg::data_t          wb_result_q;
  cpu_pkg::data_t          wb_load_data_q;

  // byte address to word index, wraps at the memory size
  assign word_idx  = mem_result[addr_width+1:2];
  assign load_data = dmem[word_idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (mem_valid && mem_store) begin
      dmem[word_idx] <= mem_store_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid  <= 1'b0;
      wb_wen_q  <= 1'b0;
      wb_load_q <= 1'b0;
    end else begin
      wb_valid  <= mem_valid;
      wb_wen_q  <= mem_wen;
      wb_load_q <= mem_load;
    end
  end

  always_ff @(posedge clk) begin
    wb_dst         <= mem_dst;
    wb_result_q    <= mem_result;
    wb_load_data_q <= load_data;
  end

  // writeback select
  assign wb_wen  = wb_valid & wb_wen_q;
  assign wb_data = wb_load_q ? wb_load_data_q : wb_result_q;

endmodule

// File: rtl/register_file.sv
module register_file (
  input  logic              clk,
  input  logic              arst_n,
  input  cpu_pkg::reg_addr_t rd_addr_a,
  input  cpu_pkg::reg_addr_t rd_addr_b,
  output cpu_pkg::data_t    rd_data_a,
  output cpu_pkg::data_t    rd_data_b,
  input  logic              wr_en,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::data_t    wr_data
);

  localparam int num_regs = 2 ** cpu_pkg::reg_addr_width;

  cpu_pkg::data_t regs [num_regs];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write-through so a reader in the same cycle sees the new value
  assign rd_data_a = (rd_addr_a == '0) ? '0 :
                     (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 :
                     (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

  // decode drops the enable for r0 writes, nothing later may bring it back
  no_r0_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_en |-> wr_addr != '0
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cpu_core_tb --Mdir obj_dir -o cpu_core_sim -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/cpu_core_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
